//--- src.f
+incdir+include
design/csr_pkg.sv
design/csr_timer.sv
design/csr_issue.sv
design/csr_regfile.sv
design/csr_unit.sv
dv/csr_unit_chk.sv
dv/csr_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = csr_unit_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/csr_unit_tb.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 8;
    // roughly 45 requests of 3 cycles plus a timer wait under 60 cycles, so ample margin
    localparam int MAX_CYCLES = 4000;
    localparam word_t ENTRY_PC = 32'h1c00_0100;

    logic      clk;
    logic      rstn;
    logic      stall;
    logic      kill;
    logic      req_valid;
    csr_op_t   req_op;
    csr_num_t  req_csr_num;
    word_t     req_wdata;
    word_t     req_wmask;
    word_t     req_pc;
    word_t     req_badv;
    logic      req_excp;
    ecode_t    req_ecode;
    esubcode_t req_esubcode;
    logic [7:0] hw_int;
    logic      ipi;
    word_t     rdata;
    word_t     redirect_pc;
    logic      flush;
    logic      excp_flush;
    logic      ertn_flush;
    ecode_t    ecode_out;
    plv_t      plv;
    logic      ie;

    // results of the last request
    word_t     got_rdata;
    word_t     got_redirect;
    logic      got_flush;
    logic      got_excp_flush;
    logic      got_ertn_flush;
    ecode_t    got_ecode;
    plv_t      got_plv;
    logic      got_ie;
    word_t     sent_pc;
    word_t     next_pc;
    int        cycles = 0;
    word_t     saved[6];
    csr_num_t  save_nums[6];

    csr_unit uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(negedge clk)
    begin
        if (uut.u_chk.failed === 1'b1)
        begin
            $display("an assertion in the bound checker failed");
            $display("ERRORS FOUND");
            $fatal(1, "checker assertion failed");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_ecode(input string name, input ecode_t got, input ecode_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_plv(input string name, input plv_t got, input plv_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // starts and ends on a falling edge, three cycles per request
    task automatic send(input csr_op_t op, input csr_num_t num, input word_t wdata,
                        input word_t wmask);
        sent_pc = next_pc;
        next_pc = next_pc + 32'd4;
        req_valid = 1'b1;
        req_op = op;
        req_csr_num = num;
        req_wdata = wdata;
        req_wmask = wmask;
        req_pc = sent_pc;
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        req_excp = 1'b0;
        got_rdata = rdata;
        got_flush = flush;
        got_redirect = redirect_pc;
        @(negedge clk);
        got_excp_flush = excp_flush;
        got_ertn_flush = ertn_flush;
        got_ecode = ecode_out;
        got_plv = plv;
        got_ie = ie;
        @(negedge clk);
    endtask

    task automatic send_excp(input ecode_t code, input word_t badv);
        req_excp = 1'b1;
        req_ecode = code;
        req_esubcode = '0;
        req_badv = badv;
        send(CSR_NOP, `CSR_CRMD, '0, '0);
    endtask

    task automatic write_csr(input csr_num_t num, input word_t data);
        send(CSR_WR, num, data, '1);
        check_bit("flush", got_flush, 1'b1);
        check_word("redirect_pc", got_redirect, sent_pc + 32'd4);
    endtask

    task automatic read_csr(input csr_num_t num, output word_t value);
        send(CSR_RD, num, '0, '0);
        check_bit("flush", got_flush, 1'b0);
        value = got_rdata;
    endtask

    task automatic test_rw();
        word_t value;
        int i;
        for (i = 0; i < 6; i++)
        begin
            saved[i] = $urandom();
            write_csr(save_nums[i], saved[i]);
        end
        for (i = 0; i < 6; i++)
        begin
            read_csr(save_nums[i], value);
            check_word("rdata", value, saved[i]);
        end
    endtask

    task automatic test_xchg();
        word_t wdata;
        word_t mask;
        word_t value;
        word_t expected;
        int b;
        wdata = $urandom();
        mask = $urandom();
        send(CSR_XCHG, `CSR_SAVE1, wdata, mask);
        check_word("rdata", got_rdata, saved[1]);
        check_bit("flush", got_flush, 1'b1);
        check_word("redirect_pc", got_redirect, sent_pc + 32'd4);
        for (b = 0; b < 32; b++)
            expected[b] = mask[b] ? wdata[b] : saved[1][b];   // masked bits from wdata
        saved[1] = expected;
        read_csr(`CSR_SAVE1, value);
        check_word("save1", value, saved[1]);
    endtask

    task automatic test_exception();
        word_t badv;
        word_t excp_pc;
        word_t value;
        write_csr(`CSR_CRMD, 32'h0000_0003);   // plv 3, ie 0
        check_plv("plv", got_plv, 2'd3);
        write_csr(`CSR_EENTRY, ENTRY_PC);
        badv = $urandom();
        send_excp(`ECODE_ALE, badv);
        excp_pc = sent_pc;
        check_bit("flush", got_flush, 1'b1);
        check_word("redirect_pc", got_redirect, ENTRY_PC);
        check_bit("excp_flush", got_excp_flush, 1'b1);
        check_bit("ertn_flush", got_ertn_flush, 1'b0);
        check_ecode("ecode_out", got_ecode, `ECODE_ALE);
        check_plv("plv", got_plv, 2'd0);
        read_csr(`CSR_ERA, value);
        check_word("era", value, excp_pc);
        read_csr(`CSR_BADV, value);
        check_word("badv", value, badv);
        read_csr(`CSR_ESTAT, value);
        check_ecode("estat.ecode", value[21:16], `ECODE_ALE);
        read_csr(`CSR_PRMD, value);
        check_word("prmd", value, 32'h0000_0003);
        send(CSR_ERTN, '0, '0, '0);
        check_bit("flush", got_flush, 1'b1);
        check_word("redirect_pc", got_redirect, excp_pc);
        check_bit("ertn_flush", got_ertn_flush, 1'b1);
        check_bit("excp_flush", got_excp_flush, 1'b0);
        check_plv("plv", got_plv, 2'd3);
    endtask

    task automatic test_interrupt();
        word_t int_pc;
        word_t value;
        write_csr(`CSR_ECFG, 32'h0000_0004);   // lie for hw_int[0]
        write_csr(`CSR_CRMD, 32'h0000_0004);   // ie on, plv 0
        check_bit("ie", got_ie, 1'b1);
        hw_int[0] = 1'b1;
        send(CSR_RD, `CSR_SAVE0, '0, '0);
        int_pc = sent_pc;
        check_bit("flush", got_flush, 1'b1);
        check_word("redirect_pc", got_redirect, ENTRY_PC);
        check_bit("excp_flush", got_excp_flush, 1'b1);
        check_ecode("ecode_out", got_ecode, `ECODE_INT);
        check_bit("ie", got_ie, 1'b0);
        hw_int[0] = 1'b0;
        read_csr(`CSR_ERA, value);
        check_word("era", value, int_pc);
        read_csr(`CSR_ESTAT, value);
        check_ecode("estat.ecode", value[21:16], `ECODE_INT);
    endtask

    task automatic test_timer();
        word_t value;
        logic ti;
        int waited;
        write_csr(`CSR_TCFG, 32'h0000_0021);   // one-shot, start at 32
        ti = 1'b0;
        waited = 0;
        while (!ti && waited <= 32 + 20)
        begin
            read_csr(`CSR_ESTAT, value);
            ti = value[`ESTAT_TI_BIT];
            waited = waited + 3;
        end
        check_bit("estat.ti", ti, 1'b1);
        write_csr(`CSR_TICLR, 32'h0000_0001);
        read_csr(`CSR_ESTAT, value);
        check_bit("estat.ti", value[`ESTAT_TI_BIT], 1'b0);
    endtask

    task automatic test_stall();
        word_t wdata;
        word_t pc;
        word_t value;
        wdata = $urandom();
        pc = next_pc;
        next_pc = next_pc + 32'd4;
        req_valid = 1'b1;
        req_op = CSR_WR;
        req_csr_num = `CSR_SAVE2;
        req_wdata = wdata;
        req_wmask = '1;
        req_pc = pc;
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        stall = 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            check_bit("flush", flush, 1'b0);
            check_word("rdata", rdata, saved[2]);
        end
        stall = 1'b0;
        #1;
        check_bit("flush", flush, 1'b1);
        check_word("redirect_pc", redirect_pc, pc + 32'd4);
        check_word("rdata", rdata, saved[2]);
        @(negedge clk);
        check_bit("flush", flush, 1'b0);
        @(negedge clk);
        saved[2] = wdata;
        read_csr(`CSR_SAVE2, value);
        check_word("save2", value, saved[2]);
    endtask

    initial
    begin
        void'($urandom(32'h1430d3c0));
        save_nums = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_ERA};
        next_pc = 32'h1c00_2000;
        rstn = 1'b0;
        stall = 1'b0;
        kill = 1'b0;
        req_valid = 1'b0;
        req_op = CSR_NOP;
        req_csr_num = '0;
        req_wdata = '0;
        req_wmask = '0;
        req_pc = '0;
        req_badv = '0;
        req_excp = 1'b0;
        req_ecode = '0;
        req_esubcode = '0;
        hw_int = '0;
        ipi = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_bit("flush", flush, 1'b0);
        check_bit("excp_flush", excp_flush, 1'b0);
        check_bit("ertn_flush", ertn_flush, 1'b0);
        check_plv("plv", plv, 2'd0);
        check_bit("ie", ie, 1'b0);

        test_rw();
        test_xchg();
        test_exception();
        test_interrupt();
        test_timer();
        test_stall();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- dv/csr_unit_chk.sv
`timescale 1ns/1ps

module csr_unit_chk (
    input logic             clk,
    input logic             rstn,
    input logic             stall,
    input logic             kill,
    input logic             req_valid,
    input csr_pkg::csr_op_t req_op,
    input logic             req_excp,
    input logic             interrupt_pending,
    input logic             flush,
    input logic             excp_flush,
    input logic             ertn_flush
);
    import csr_pkg::*;

    logic failed;   // sticky

    initial
        failed = 1'b0;

    flush_pulse: assert property (@(posedge clk) disable iff (!rstn) flush |=> !flush)
    else
    begin
        failed = 1'b1;
        $error("flush stayed high for more than one cycle");
    end

    excp_pulse: assert property (@(posedge clk) disable iff (!rstn) excp_flush |=> !excp_flush)
    else
    begin
        failed = 1'b1;
        $error("excp_flush stayed high for more than one cycle");
    end

    ertn_pulse: assert property (@(posedge clk) disable iff (!rstn) ertn_flush |=> !ertn_flush)
    else
    begin
        failed = 1'b1;
        $error("ertn_flush stayed high for more than one cycle");
    end

    // every commit pulse follows a flush from the issue stage
    flush_order: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |-> $past(flush))
    else
    begin
        failed = 1'b1;
        $error("excp_flush or ertn_flush without a flush the cycle before");
    end

    read_quiet: assert property (@(posedge clk) disable iff (!rstn)
        (req_valid && !stall && !kill && req_op == CSR_RD && !req_excp && !interrupt_pending)
        |=> !flush)
    else
    begin
        failed = 1'b1;
        $error("flush raised in the cycle after a read");
    end

endmodule

bind csr_unit csr_unit_chk u_chk (
    .clk(clk),
    .rstn(rstn),
    .stall(stall),
    .kill(kill),
    .req_valid(req_valid),
    .req_op(req_op),
    .req_excp(req_excp),
    .interrupt_pending(interrupt_pending),
    .flush(flush),
    .excp_flush(excp_flush),
    .ertn_flush(ertn_flush)
);

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall,
    input  logic                kill,
    input  logic                req_valid,
    input  csr_pkg::csr_op_t    req_op,
    input  csr_pkg::csr_num_t   req_csr_num,
    input  csr_pkg::word_t      req_wdata,
    input  csr_pkg::word_t      req_wmask,
    input  csr_pkg::word_t      req_pc,
    input  csr_pkg::word_t      req_badv,
    input  logic                req_excp,
    input  csr_pkg::ecode_t     req_ecode,
    input  csr_pkg::esubcode_t  req_esubcode,
    input  logic [7:0]          hw_int,
    input  logic                ipi,
    output csr_pkg::word_t      rdata,
    output csr_pkg::word_t      redirect_pc,
    output logic                flush,
    output logic                excp_flush,
    output logic                ertn_flush,
    output csr_pkg::ecode_t     ecode_out,
    output csr_pkg::plv_t       plv,
    output logic                ie
);
    import csr_pkg::*;

    // issue to register file
    csr_num_t     read_num;
    word_t        read_data;
    word_t        era;
    word_t        eentry;
    logic         interrupt_pending;

    // registered stage, consumed at commit
    logic         commit_valid;
    commit_kind_t commit_kind;
    csr_num_t     commit_csr_num;
    word_t        commit_wdata;
    word_t        commit_pc;
    ecode_t       commit_ecode;
    esubcode_t    commit_esubcode;
    word_t        commit_badv;

    // timer side
    logic         tcfg_we;
    logic         ticlr_we;
    word_t        tcfg;
    word_t        tval;
    logic         timer_int;

    csr_issue u_issue (.*);

    csr_regfile u_regfile (.*);

    csr_timer u_timer (
        .wdata(commit_wdata),
        .*
    );

endmodule

//--- design/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_regfile (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic                  commit_valid,
    input  csr_pkg::commit_kind_t commit_kind,
    input  csr_pkg::csr_num_t     commit_csr_num,
    input  csr_pkg::word_t        commit_wdata,
    input  csr_pkg::word_t        commit_pc,
    input  csr_pkg::ecode_t       commit_ecode,
    input  csr_pkg::esubcode_t    commit_esubcode,
    input  csr_pkg::word_t        commit_badv,
    input  csr_pkg::csr_num_t     read_num,
    output csr_pkg::word_t        read_data,
    input  logic [7:0]            hw_int,
    input  logic                  ipi,
    input  csr_pkg::word_t        tcfg,
    input  csr_pkg::word_t        tval,
    input  logic                  timer_int,
    output csr_pkg::word_t        era,
    output csr_pkg::word_t        eentry,
    output logic                  interrupt_pending,
    output logic                  tcfg_we,
    output logic                  ticlr_we,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output csr_pkg::ecode_t       ecode_out,
    output csr_pkg::plv_t         plv,
    output logic                  ie
);
    import csr_pkg::*;

    logic [8:0]            crmd;
    logic [2:0]            prmd;
    logic [`INT_LINES-1:0] ecfg_lie;
    logic [1:0]            estat_is;
    ecode_t                estat_ecode;
    esubcode_t             estat_esubcode;
    word_t                 era_q;
    word_t                 badv;
    logic [25:0]           eentry_q;
    word_t                 save0;
    word_t                 save1;
    word_t                 save2;
    word_t                 save3;
    word_t                 tid;
    logic [`INT_LINES-1:0] int_src;
    word_t                 estat;
    logic                  commit_fire;
    logic                  csr_write;

    assign commit_fire = commit_valid && !stall;
    assign csr_write = commit_fire && (commit_kind == KIND_WRITE);
    assign tcfg_we = csr_write && (commit_csr_num == `CSR_TCFG);
    assign ticlr_we = csr_write && (commit_csr_num == `CSR_TICLR);

    // live interrupt lines, same layout as estat[12:0]
    always_comb
    begin
        int_src = '0;
        int_src[1:0] = estat_is;
        int_src[9:2] = hw_int;
        int_src[`ESTAT_TI_BIT] = timer_int;
        int_src[`ESTAT_IPI_BIT] = ipi;
    end

    assign estat = {1'b0, estat_esubcode, estat_ecode, 3'b000, int_src};
    assign interrupt_pending = |(int_src & ecfg_lie) && crmd[`CRMD_IE_BIT];

    assign era = era_q;
    assign eentry = {eentry_q, 6'b0};
    assign plv = crmd[1:0];
    assign ie = crmd[`CRMD_IE_BIT];
    assign ecode_out = excp_flush ? estat_ecode : '0;

    always_comb
    begin
        case (read_num)
            `CSR_CRMD:   read_data = {23'b0, crmd};
            `CSR_PRMD:   read_data = {29'b0, prmd};
            `CSR_ECFG:   read_data = {19'b0, ecfg_lie};
            `CSR_ESTAT:  read_data = estat;
            `CSR_ERA:    read_data = era_q;
            `CSR_BADV:   read_data = badv;
            `CSR_EENTRY: read_data = eentry;
            `CSR_SAVE0:  read_data = save0;
            `CSR_SAVE1:  read_data = save1;
            `CSR_SAVE2:  read_data = save2;
            `CSR_SAVE3:  read_data = save3;
            `CSR_TID:    read_data = tid;
            `CSR_TCFG:   read_data = tcfg;
            `CSR_TVAL:   read_data = tval;
            default:     read_data = '0;    // ticlr and unknown read zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd <= '0;
            prmd <= '0;
            ecfg_lie <= '0;
            estat_is <= '0;
            estat_ecode <= '0;
            estat_esubcode <= '0;
            era_q <= '0;
            badv <= '0;
            eentry_q <= '0;
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
            tid <= '0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            if (commit_fire)
            begin
                case (commit_kind)
                    KIND_ENTRY:
                    begin
                        prmd <= crmd[2:0];  // save plv/ie
                        crmd[2:0] <= 3'b000;
                        era_q <= commit_pc;
                        estat_ecode <= commit_ecode;
                        estat_esubcode <= commit_esubcode;
                        if (commit_ecode == `ECODE_ALE)
                            badv <= commit_badv;
                        excp_flush <= 1'b1;
                    end
                    KIND_ERTN:
                    begin
                        crmd[2:0] <= prmd;
                        ertn_flush <= 1'b1;
                    end
                    KIND_WRITE:
                    begin
                        case (commit_csr_num)
                            `CSR_CRMD:   crmd <= commit_wdata[8:0];
                            `CSR_PRMD:   prmd <= commit_wdata[2:0];
                            `CSR_ECFG:   ecfg_lie <= {commit_wdata[12:11], 1'b0, commit_wdata[9:0]};
                            `CSR_ESTAT:  estat_is <= commit_wdata[1:0]; // only sw bits
                            `CSR_ERA:    era_q <= commit_wdata;
                            `CSR_BADV:   badv <= commit_wdata;
                            `CSR_EENTRY: eentry_q <= commit_wdata[31:6];
                            `CSR_SAVE0:  save0 <= commit_wdata;
                            `CSR_SAVE1:  save1 <= commit_wdata;
                            `CSR_SAVE2:  save2 <= commit_wdata;
                            `CSR_SAVE3:  save3 <= commit_wdata;
                            `CSR_TID:    tid <= commit_wdata;
                            default:     ;
                        endcase
                    end
                    default:
                        ;
                endcase
            end
        end
    end

endmodule

//--- design/csr_issue.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_issue (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic                  kill,
    input  logic                  req_valid,
    input  csr_pkg::csr_op_t      req_op,
    input  csr_pkg::csr_num_t     req_csr_num,
    input  csr_pkg::word_t        req_wdata,
    input  csr_pkg::word_t        req_wmask,
    input  csr_pkg::word_t        req_pc,
    input  logic                  req_excp,
    input  csr_pkg::ecode_t       req_ecode,
    input  csr_pkg::esubcode_t    req_esubcode,
    input  csr_pkg::word_t        req_badv,
    input  logic                  interrupt_pending,
    input  csr_pkg::word_t        read_data,
    input  csr_pkg::word_t        era,
    input  csr_pkg::word_t        eentry,
    output csr_pkg::csr_num_t     read_num,
    output csr_pkg::word_t        rdata,
    output csr_pkg::word_t        redirect_pc,
    output logic                  flush,
    output logic                  commit_valid,
    output csr_pkg::commit_kind_t commit_kind,
    output csr_pkg::csr_num_t     commit_csr_num,
    output csr_pkg::word_t        commit_wdata,
    output csr_pkg::word_t        commit_pc,
    output csr_pkg::ecode_t       commit_ecode,
    output csr_pkg::esubcode_t    commit_esubcode,
    output csr_pkg::word_t        commit_badv
);
    import csr_pkg::*;

    logic         accept;
    logic         take_int;
    word_t        mask;
    word_t        merged;
    commit_kind_t next_kind;
    ecode_t       next_ecode;
    esubcode_t    next_esubcode;
    word_t        next_redirect;
    logic         next_flush;
    logic         flush_q;

    assign read_num = req_csr_num;
    assign accept = req_valid && !kill && !stall;

    // an entry already waiting in the stage owns the interrupt
    assign take_int = interrupt_pending && !(commit_valid && commit_kind == KIND_ENTRY);

    assign mask = (req_op == CSR_XCHG) ? req_wmask : '1; // plain write takes all bits
    assign merged = (read_data & ~mask) | (req_wdata & mask);

    always_comb
    begin
        next_kind = KIND_NONE;
        next_ecode = req_ecode;
        next_esubcode = req_esubcode;
        next_redirect = req_pc + 32'd4;
        if (take_int)
        begin
            next_kind = KIND_ENTRY;
            next_ecode = `ECODE_INT;
            next_esubcode = '0;
            next_redirect = eentry;
        end
        else if (req_excp)
        begin
            next_kind = KIND_ENTRY;
            next_redirect = eentry;
        end
        else
        begin
            case (req_op)
                CSR_RD:
                    next_kind = KIND_READ;
                CSR_WR, CSR_XCHG:
                    next_kind = KIND_WRITE;
                CSR_ERTN:
                begin
                    next_kind = KIND_ERTN;
                    next_redirect = era;
                end
                default:
                    next_kind = KIND_NONE;
            endcase
        end
    end

    // reads and nops leave the pipe alone
    assign next_flush = (next_kind != KIND_NONE) && (next_kind != KIND_READ);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit_valid <= 1'b0;
            commit_kind <= KIND_NONE;
            flush_q <= 1'b0;
        end
        else if (!stall)
        begin
            commit_valid <= accept;           // kill loads an empty stage
            commit_kind <= accept ? next_kind : KIND_NONE;
            flush_q <= accept && next_flush;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rdata <= read_data;               // old value
            commit_csr_num <= req_csr_num;
            commit_wdata <= merged;
            commit_pc <= req_pc;
            commit_ecode <= next_ecode;
            commit_esubcode <= next_esubcode;
            commit_badv <= req_badv;
            if (next_flush)
                redirect_pc <= next_redirect;
        end
    end

    // held stage shows its flush once the stall drops
    assign flush = flush_q && !stall;

endmodule

//--- design/csr_timer.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_timer #(
    parameter int timer_w = `TIMER_W
) (
    input  logic           clk,
    input  logic           rstn,
    input  logic           tcfg_we,
    input  csr_pkg::word_t wdata,
    input  logic           ticlr_we,
    output csr_pkg::word_t tcfg,
    output csr_pkg::word_t tval,
    output logic           timer_int
);
    import csr_pkg::*;

    logic [timer_w-1:0] tcfg_q;
    logic [timer_w-1:0] tval_q;
    logic [timer_w-1:0] init_val;
    logic               running;

    assign init_val = {tcfg_q[timer_w-1:2], 2'b00}; // units of 4
    assign running = tcfg_q[`TCFG_EN_BIT] && !tcfg_we;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_q <= '0;
            tval_q <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
            begin
                tcfg_q <= wdata[timer_w-1:0];
                if (wdata[`TCFG_EN_BIT])
                    tval_q <= {wdata[timer_w-1:2], 2'b00};
            end
            else if (running)
            begin
                if (tval_q == '0)
                    tval_q <= tcfg_q[`TCFG_PER_BIT] ? init_val : '1; // one-shot parks at all ones
                else if (tval_q != '1)
                    tval_q <= tval_q - 1'b1;
            end

            if (ticlr_we && wdata[`TICLR_CLR_BIT])
                timer_int <= 1'b0;
            else if (running && tval_q == '0)
                timer_int <= 1'b1;
        end
    end

    assign tcfg = word_t'(tcfg_q);
    assign tval = word_t'(tval_q);

endmodule

//--- design/csr_pkg.sv
package csr_pkg;

    typedef enum logic [2:0] {
        CSR_NOP,
        CSR_RD,
        CSR_WR,
        CSR_XCHG,
        CSR_ERTN
    } csr_op_t;

    // what the issue stage hands over for commit
    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_READ,
        KIND_WRITE,
        KIND_ENTRY,
        KIND_ERTN
    } commit_kind_t;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;

endpackage

//--- include/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// csr numbers
`define CSR_CRMD      14'h000
`define CSR_PRMD      14'h001
`define CSR_ECFG      14'h004
`define CSR_ESTAT     14'h005
`define CSR_ERA       14'h006
`define CSR_BADV      14'h007
`define CSR_EENTRY    14'h00c
`define CSR_SAVE0     14'h030
`define CSR_SAVE1     14'h031
`define CSR_SAVE2     14'h032
`define CSR_SAVE3     14'h033
`define CSR_TID       14'h040
`define CSR_TCFG      14'h041
`define CSR_TVAL      14'h042
`define CSR_TICLR     14'h044

// exception codes
`define ECODE_INT     6'h00
`define ECODE_ALE     6'h09
`define ECODE_SYS     6'h0b
`define ECODE_BRK     6'h0c

`define TIMER_W       32

// field positions
`define CRMD_IE_BIT   2
`define TCFG_EN_BIT   0
`define TCFG_PER_BIT  1
`define TICLR_CLR_BIT 0
`define ESTAT_TI_BIT  11
`define ESTAT_IPI_BIT 12

// is[1:0], hw[7:0], unused, ti, ipi
`define INT_LINES     13

`endif
